// ==== Makefile ====
TOP := tb_dcache
SIM := obj_dir/V$(TOP)

$(SIM): sources.f $(wildcard design/*.sv test/*.sv)
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f sources.f

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== design/dcache_ctrl.sv ====
/*
 * dcache controller
 * lookup, write-hit merge, dirty writeback, line refill, uncached
 * device access, random replacement and hit/miss counters
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cpu_valid_i,
    input  cpu_req_t                            cpu_req_i,
    output logic                                cpu_ready_o,
    output logic [WORD_BITS-1:0]                cpu_rdata_o,
    input  logic                                hit_i,
    input  logic [1:0]                          hit_way_i,
    input  tag_entry_t                          victim_entry_i,
    output logic                                lookup_o,
    output logic [INDEX_W-1:0]                  index_o,
    output logic [TAG_W-1:0]                    tag_o,
    output logic                                tag_we_o,
    output logic [1:0]                          tag_way_o,
    output tag_entry_t                          tag_wentry_o,
    output logic [1:0]                          victim_way_o,
    output logic [NUM_WAYS-1:0]                 sram_ce_o,
    output logic [NUM_WAYS-1:0]                 sram_we_o,
    output logic [INDEX_W-1:0]                  sram_addr_o,
    output logic [LINE_BITS-1:0]                sram_wmask_o,
    output logic [LINE_BITS-1:0]                sram_wdata_o,
    input  logic [NUM_WAYS-1:0][LINE_BITS-1:0]  sram_rdata_i,
    output logic                                mem_rd_valid_o,
    output mem_rd_req_t                         mem_rd_req_o,
    input  logic                                mem_rd_ready_i,
    input  logic [WORD_BITS-1:0]                mem_rd_data_i,
    input  logic                                mem_rd_last_i,
    output logic                                mem_wr_valid_o,
    output mem_wr_req_t                         mem_wr_req_o,
    output logic [WORD_BITS-1:0]                mem_wr_data_o,
    input  logic                                mem_wr_ready_i,
    input  logic                                mem_wr_last_i,
    output logic [63:0]                         hit_count_o,
    output logic [63:0]                         miss_count_o
);

    typedef enum logic [2:0] {
        IDLE, LOOKUP, RESPOND, WRITEBACK, REFILL, DEV_RD, DEV_WR
    } state_e;

    state_e               state_q;
    cpu_req_t             req_q;
    dcache_addr_u         cpu_addr;
    dcache_addr_u         req_addr;
    logic [1:0]           repl_ptr_q;
    logic [1:0]           victim_q;
    logic [LINE_BITS-1:0] line_q;        // hit data, victim data or refill buffer
    logic [LINE_BITS-1:0] refill_line;
    logic [LINE_BITS-1:0] fill_line;
    mem_rd_req_t          line_rd_req;
    logic                 accept;
    logic                 cpu_cacheable;
    logic                 req_half;
    logic                 wr_hit;
    logic                 fill_done;

    // store bytes of one word into its half of a line
    function automatic logic [LINE_BITS-1:0] merge_line(
        input logic [LINE_BITS-1:0] line,
        input cpu_req_t             req,
        input logic                 half
    );
        logic [LINE_BITS-1:0] merged;
        merged = line;
        for (int b = 0; b < 8; b++) begin
            if (req.wstrb[b]) begin
                merged[{half, 6'(b * 8)} +: 8] = req.wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic [LINE_BITS-1:0] byte_mask(
        input logic [7:0] strb,
        input logic       half
    );
        logic [LINE_BITS-1:0] mask;
        mask = '0;
        for (int b = 0; b < 8; b++) begin
            mask[{half, 6'(b * 8)} +: 8] = {8{strb[b]}};
        end
        return mask;
    endfunction

    assign cpu_addr.raw  = cpu_req_i.addr;
    assign req_addr.raw  = req_q.addr;
    assign accept        = (state_q == IDLE) && cpu_valid_i && !cpu_ready_o;
    assign cpu_cacheable = cpu_addr.f.tag[TAG_W-1 -: 5] == MEM_REGION_TAG;
    assign req_half      = req_addr.f.offset[3];
    assign wr_hit        = (state_q == LOOKUP) && hit_i && req_q.we;
    assign fill_done     = (state_q == REFILL) && mem_rd_ready_i && mem_rd_last_i;

    // second beat arrives with last, first one is already buffered
    assign refill_line = {mem_rd_data_i, line_q[WORD_BITS-1:0]};
    assign fill_line   = req_q.we ? merge_line(refill_line, req_q, req_half) : refill_line;
    assign line_rd_req = '{addr: {req_addr.f.tag, req_addr.f.index, OFFSET_W'(0)},
                           len:  8'(BEATS_PER_LINE)};

    // tag array side
    assign lookup_o     = accept && cpu_cacheable;
    assign index_o      = (state_q == IDLE) ? cpu_addr.f.index : req_addr.f.index;
    assign tag_o        = (state_q == IDLE) ? cpu_addr.f.tag : req_addr.f.tag;
    assign victim_way_o = repl_ptr_q;
    assign tag_we_o     = wr_hit || fill_done;
    assign tag_way_o    = wr_hit ? hit_way_i : victim_q;
    assign tag_wentry_o = '{tag: req_addr.f.tag, valid: 1'b1, dirty: req_q.we};

    // data SRAM side
    assign sram_addr_o = index_o;

    always_comb begin
        sram_ce_o    = '0;
        sram_we_o    = '0;
        sram_wmask_o = byte_mask(req_q.wstrb, req_half);
        sram_wdata_o = {2{req_q.wdata}};
        if (lookup_o) begin
            sram_ce_o = '1;   // read all ways with the tags
        end else if (wr_hit) begin
            sram_ce_o[hit_way_i] = 1'b1;
            sram_we_o[hit_way_i] = 1'b1;
        end else if (fill_done) begin
            sram_ce_o[victim_q] = 1'b1;
            sram_we_o[victim_q] = 1'b1;
            sram_wmask_o        = '1;
            sram_wdata_o        = fill_line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q        <= IDLE;
            cpu_ready_o    <= 1'b0;
            mem_rd_valid_o <= 1'b0;
            mem_wr_valid_o <= 1'b0;
            repl_ptr_q     <= '0;
            hit_count_o    <= '0;
            miss_count_o   <= '0;
        end else begin
            cpu_ready_o <= 1'b0;
            repl_ptr_q  <= repl_ptr_q + 2'd1;   // free-running victim pointer
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        req_q    <= cpu_req_i;
                        victim_q <= repl_ptr_q;
                        if (cpu_cacheable) begin
                            state_q <= LOOKUP;
                        end else if (cpu_req_i.we) begin
                            mem_wr_valid_o <= 1'b1;
                            mem_wr_req_o   <= '{addr: cpu_req_i.addr, len: 8'd1,
                                                strb: cpu_req_i.wstrb};
                            mem_wr_data_o  <= cpu_req_i.wdata;
                            state_q        <= DEV_WR;
                        end else begin
                            mem_rd_valid_o <= 1'b1;
                            mem_rd_req_o   <= '{addr: cpu_req_i.addr, len: 8'd1};
                            state_q        <= DEV_RD;
                        end
                    end
                end
                LOOKUP: begin
                    line_q <= sram_rdata_i[hit_i ? hit_way_i : victim_q];
                    if (hit_i) begin
                        hit_count_o <= hit_count_o + 64'd1;
                        state_q     <= RESPOND;
                    end else begin
                        miss_count_o <= miss_count_o + 64'd1;
                        if (victim_entry_i.valid && victim_entry_i.dirty) begin
                            mem_wr_valid_o <= 1'b1;
                            mem_wr_req_o   <= '{addr: {victim_entry_i.tag, req_addr.f.index,
                                                       OFFSET_W'(0)},
                                                len:  8'(BEATS_PER_LINE),
                                                strb: 8'hff};
                            mem_wr_data_o  <= sram_rdata_i[victim_q][WORD_BITS-1:0];
                            state_q        <= WRITEBACK;
                        end else begin
                            mem_rd_valid_o <= 1'b1;
                            mem_rd_req_o   <= line_rd_req;
                            state_q        <= REFILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (mem_wr_ready_i) begin
                        if (mem_wr_last_i) begin
                            mem_wr_valid_o <= 1'b0;
                            mem_rd_valid_o <= 1'b1;
                            mem_rd_req_o   <= line_rd_req;
                            state_q        <= REFILL;
                        end else begin
                            mem_wr_data_o <= line_q[LINE_BITS-1 -: WORD_BITS];
                        end
                    end
                end
                REFILL: begin
                    if (mem_rd_ready_i) begin
                        if (mem_rd_last_i) begin
                            mem_rd_valid_o <= 1'b0;
                            line_q         <= fill_line;   // SRAM written this cycle too
                            state_q        <= RESPOND;
                        end else begin
                            line_q[WORD_BITS-1:0] <= mem_rd_data_i;
                        end
                    end
                end
                DEV_RD: begin
                    if (mem_rd_ready_i && mem_rd_last_i) begin
                        mem_rd_valid_o <= 1'b0;
                        line_q         <= {2{mem_rd_data_i}};   // either half answers
                        state_q        <= RESPOND;
                    end
                end
                DEV_WR: begin
                    if (mem_wr_ready_i && mem_wr_last_i) begin
                        mem_wr_valid_o <= 1'b0;
                        state_q        <= RESPOND;
                    end
                end
                RESPOND: begin
                    cpu_ready_o <= 1'b1;
                    cpu_rdata_o <= req_half ? line_q[LINE_BITS-1 -: WORD_BITS]
                                            : line_q[WORD_BITS-1:0];
                    state_q     <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_pkg.sv ====
/*
 * dcache package
 * cache geometry, the two-way address view and the CPU and memory
 * port structs shared by the controller, tag array and top level
 */
`default_nettype none

package dcache_pkg;

    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 64;
    localparam int LINE_BYTES     = 16;
    localparam int TAG_W          = 22;
    localparam int INDEX_W        = 6;
    localparam int OFFSET_W       = 4;
    localparam int BEATS_PER_LINE = 2;
    localparam int WORD_BITS      = 64;
    localparam int LINE_BITS      = LINE_BYTES * 8;

    // 0x8000_0000 .. 0x87ff_ffff
    localparam logic [4:0] MEM_REGION_TAG = 5'b10000;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;   // bit 3 picks the line half
    } dcache_addr_fields_t;

    typedef union packed {
        logic [31:0]         raw;
        dcache_addr_fields_t f;
    } dcache_addr_u;

    typedef struct packed {
        logic                 we;
        logic [31:0]          addr;
        logic [WORD_BITS-1:0] wdata;
        logic [7:0]           wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;     // beats, 1 or 2
    } mem_rd_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [7:0]  strb;
    } mem_wr_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
        logic             dirty;
    } tag_entry_t;

endpackage

`default_nettype wire

// ==== design/dcache_sram.sv ====
/*
 * dcache data SRAM
 * 128-bit x 64-entry single-port macro model, bit-maskable write,
 * registered read
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_sram (
    input  logic         clk,
    input  logic         ce_i,
    input  logic         we_i,
    input  logic [5:0]   addr_i,
    input  logic [127:0] wmask_i,   // 1 = write this bit
    input  logic [127:0] wdata_i,
    output logic [127:0] rdata_o
);

    logic [127:0] mem_q [64];

    always_ff @(posedge clk) begin
        if (ce_i) begin
            if (we_i) begin
                mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
            end else begin
                rdata_o <= mem_q[addr_i];   // holds until next read
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_tag_array.sv ====
/*
 * dcache tag array
 * tag, valid and dirty per set and way, registered 4-way compare
 * and victim entry readout one cycle after lookup
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               lookup_i,
    input  logic [INDEX_W-1:0] index_i,
    input  logic [TAG_W-1:0]   tag_i,
    input  logic               tag_we_i,
    input  logic [1:0]         tag_way_i,
    input  tag_entry_t         tag_wentry_i,
    input  logic [1:0]         victim_way_i,
    output logic               hit_o,
    output logic [1:0]         hit_way_o,
    output tag_entry_t         victim_entry_o
);

    logic [TAG_W-1:0]    tag_mem   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] dirty_mem [NUM_SETS];
    logic [NUM_WAYS-1:0] valid_q   [NUM_SETS];
    logic [NUM_WAYS-1:0] hit_vec_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
            hit_vec_q <= '0;
        end else begin
            if (tag_we_i) begin
                valid_q[index_i][tag_way_i] <= tag_wentry_i.valid;
            end
            if (lookup_i) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    hit_vec_q[w] <= valid_q[index_i][w] && (tag_mem[index_i][w] == tag_i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_mem[index_i][tag_way_i]   <= tag_wentry_i.tag;
            dirty_mem[index_i][tag_way_i] <= tag_wentry_i.dirty;
        end
        if (lookup_i) begin   // writeback address and dirty flag
            victim_entry_o.tag   <= tag_mem[index_i][victim_way_i];
            victim_entry_o.valid <= valid_q[index_i][victim_way_i];
            victim_entry_o.dirty <= dirty_mem[index_i][victim_way_i];
        end
    end

    // at most one way matches
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec_q[w]) begin
                hit_way_o = 2'(w);
            end
        end
    end

    assign hit_o = |hit_vec_q;

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
/*
 * dcache top
 * 4-way write-back data cache, controller over tag array and one
 * data SRAM per way, with CPU port and split memory burst ports
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_valid_i,
    input  cpu_req_t             cpu_req_i,
    output logic                 cpu_ready_o,
    output logic [WORD_BITS-1:0] cpu_rdata_o,
    output logic                 mem_rd_valid_o,
    output mem_rd_req_t          mem_rd_req_o,
    input  logic                 mem_rd_ready_i,
    input  logic [WORD_BITS-1:0] mem_rd_data_i,
    input  logic                 mem_rd_last_i,
    output logic                 mem_wr_valid_o,
    output mem_wr_req_t          mem_wr_req_o,
    output logic [WORD_BITS-1:0] mem_wr_data_o,
    input  logic                 mem_wr_ready_i,
    input  logic                 mem_wr_last_i,
    output logic [63:0]          hit_count_o,
    output logic [63:0]          miss_count_o
);

    logic                               hit;
    logic [1:0]                         hit_way;
    tag_entry_t                         victim_entry;
    logic                               lookup;
    logic [INDEX_W-1:0]                 index;
    logic [TAG_W-1:0]                   tag;
    logic                               tag_we;
    logic [1:0]                         tag_way;
    tag_entry_t                         tag_wentry;
    logic [1:0]                         victim_way;
    logic [NUM_WAYS-1:0]                sram_ce;
    logic [NUM_WAYS-1:0]                sram_we;
    logic [INDEX_W-1:0]                 sram_addr;
    logic [LINE_BITS-1:0]               sram_wmask;
    logic [LINE_BITS-1:0]               sram_wdata;
    logic [NUM_WAYS-1:0][LINE_BITS-1:0] sram_rdata;

    dcache_ctrl u_ctrl (
        .clk, .rst,
        .cpu_valid_i, .cpu_req_i, .cpu_ready_o, .cpu_rdata_o,
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_entry_i (victim_entry),
        .lookup_o       (lookup),
        .index_o        (index),
        .tag_o          (tag),
        .tag_we_o       (tag_we),
        .tag_way_o      (tag_way),
        .tag_wentry_o   (tag_wentry),
        .victim_way_o   (victim_way),
        .sram_ce_o      (sram_ce),
        .sram_we_o      (sram_we),
        .sram_addr_o    (sram_addr),
        .sram_wmask_o   (sram_wmask),
        .sram_wdata_o   (sram_wdata),
        .sram_rdata_i   (sram_rdata),
        .mem_rd_valid_o, .mem_rd_req_o, .mem_rd_ready_i, .mem_rd_data_i, .mem_rd_last_i,
        .mem_wr_valid_o, .mem_wr_req_o, .mem_wr_data_o, .mem_wr_ready_i, .mem_wr_last_i,
        .hit_count_o, .miss_count_o
    );

    dcache_tag_array u_tag_array (
        .clk, .rst,
        .lookup_i       (lookup),
        .index_i        (index),
        .tag_i          (tag),
        .tag_we_i       (tag_we),
        .tag_way_i      (tag_way),
        .tag_wentry_i   (tag_wentry),
        .victim_way_i   (victim_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_entry_o (victim_entry)
    );

    // one 128 x 64 macro holds a whole way
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_sram u_sram (
            .clk,
            .ce_i    (sram_ce[w]),
            .we_i    (sram_we[w]),
            .addr_i  (sram_addr),
            .wmask_i (sram_wmask),
            .wdata_i (sram_wdata),
            .rdata_o (sram_rdata[w])
        );
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/dcache_pkg.sv
design/dcache_sram.sv
design/dcache_tag_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// ==== test/tb_dcache.sv ====
/*
 * dcache testbench
 * random CPU loads and stores against a shadow memory, device
 * accesses, hit latency and counter checks, writeback burst monitor
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int          NUM_REQ   = 400;
    localparam int          TIMEOUT   = 200;
    localparam int          MEM_WORDS = 16384;
    localparam logic [31:0] MEM_BASE  = 32'h8000_0000;
    localparam logic [31:0] DEV_BASE  = 32'h1000_0000;

    logic        clk;
    logic        rst;
    logic        cpu_valid;
    cpu_req_t    cpu_req;
    logic        cpu_ready;
    logic [63:0] cpu_rdata;
    logic        mem_rd_valid;
    mem_rd_req_t mem_rd_req;
    logic        mem_rd_ready;
    logic [63:0] mem_rd_data;
    logic        mem_rd_last;
    logic        mem_wr_valid;
    mem_wr_req_t mem_wr_req;
    logic [63:0] mem_wr_data;
    logic        mem_wr_ready;
    logic        mem_wr_last;
    logic [63:0] hit_count;
    logic [63:0] miss_count;

    logic [31:0] lfsr_q;
    logic [63:0] shadow [MEM_WORDS];
    logic [63:0] dev_shadow [4];
    cpu_req_t    cur_req;
    int          wr_beats = 0;
    int          writebacks = 0;
    int          cacheable_reqs = 0;

    dcache_top uut (
        .clk, .rst,
        .cpu_valid_i    (cpu_valid),
        .cpu_req_i      (cpu_req),
        .cpu_ready_o    (cpu_ready),
        .cpu_rdata_o    (cpu_rdata),
        .mem_rd_valid_o (mem_rd_valid),
        .mem_rd_req_o   (mem_rd_req),
        .mem_rd_ready_i (mem_rd_ready),
        .mem_rd_data_i  (mem_rd_data),
        .mem_rd_last_i  (mem_rd_last),
        .mem_wr_valid_o (mem_wr_valid),
        .mem_wr_req_o   (mem_wr_req),
        .mem_wr_data_o  (mem_wr_data),
        .mem_wr_ready_i (mem_wr_ready),
        .mem_wr_last_i  (mem_wr_last),
        .hit_count_o    (hit_count),
        .miss_count_o   (miss_count)
    );

    tb_mem_model u_mem (
        .clk, .rst,
        .rd_valid_i (mem_rd_valid),
        .rd_req_i   (mem_rd_req),
        .rd_ready_o (mem_rd_ready),
        .rd_data_o  (mem_rd_data),
        .rd_last_o  (mem_rd_last),
        .wr_valid_i (mem_wr_valid),
        .wr_req_i   (mem_wr_req),
        .wr_data_i  (mem_wr_data),
        .wr_ready_o (mem_wr_ready),
        .wr_last_o  (mem_wr_last)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
    endtask

    function automatic logic is_cacheable(input logic [31:0] addr);
        return addr[31:27] == MEM_REGION_TAG;
    endfunction

    function automatic logic [63:0] merge_word(input logic [63:0] old, input logic [63:0] data,
                                               input logic [7:0] strb);
        logic [63:0] w;
        w = old;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return w;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: %s = 0x%h, expected 0x%h",
                               $time, name, got, exp));
        end
    endtask

    // 6 tags over 4 sets, more tags than ways, plus 4 device registers
    task automatic make_request(output cpu_req_t req);
        logic [63:0] r;
        logic [31:0] tag_sel;
        logic [31:0] idx_sel;
        take_bits(3, r);
        if (r[2:0] == 3'd0) begin
            take_bits(2, r);
            req.addr = DEV_BASE | {27'd0, r[1:0], 3'd0};
        end else begin
            take_bits(6, r);
            tag_sel  = 32'(r[5:3]) % 32'd6;
            idx_sel  = 32'(r[2:1]) * 32'd17;
            req.addr = MEM_BASE | (tag_sel << 10) | (idx_sel << 4) | {28'd0, r[0], 3'd0};
        end
        take_bits(1, r);
        req.we = r[0];
        take_bits(64, r);
        req.wdata = r;
        take_bits(8, r);
        req.wstrb = r[7:0];
    endtask

    // valid stays up after the ready pulse until the next drive edge
    task automatic run_request(input cpu_req_t req, output logic [63:0] rdata,
                               output int latency);
        int waited;
        waited = 0;
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_req   <= req;
        cur_req   = req;
        do begin
            @(negedge clk);
            waited++;
            if (!cpu_ready && waited >= TIMEOUT) begin
                fail_run($sformatf("request to 0x%h got no cpu_ready_o within %0d cycles",
                                   req.addr, TIMEOUT));
            end
        end while (!cpu_ready);
        rdata   = cpu_rdata;
        latency = waited - 2;   // drive edge and accept edge come first
    endtask

    // write bursts as the responder accepts them
    always @(negedge clk) begin
        if (!rst && mem_wr_valid && mem_wr_ready) begin
            wr_beats = wr_beats + 1;
            if (mem_wr_last) begin
                if (is_cacheable(mem_wr_req.addr)) begin
                    check_value("writeback beats", 64'(wr_beats), 64'd2);
                    check_value("mem_wr_req_o.addr[3:0]", 64'(mem_wr_req.addr[3:0]), 64'd0);
                    writebacks = writebacks + 1;
                end else begin
                    check_value("device write beats", 64'(wr_beats), 64'd1);
                    check_value("mem_wr_req_o.strb", 64'(mem_wr_req.strb),
                                64'(cur_req.wstrb));
                end
                wr_beats = 0;
            end
        end
    end

    initial begin
        cpu_req_t    req;
        logic [63:0] rdata;
        logic [63:0] r;
        logic [63:0] hits0;
        logic [63:0] misses0;
        logic [13:0] widx;
        logic [1:0]  didx;
        int          lat;
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        cur_req   = '0;
        lfsr_q    = 32'ha49f;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = u_mem.mem_q[i];
        end
        for (int k = 0; k < 4; k++) begin
            dev_shadow[k] = u_mem.dev_q[k];
        end

        for (int n = 0; n < NUM_REQ; n++) begin
            make_request(req);
            hits0   = hit_count;
            misses0 = miss_count;
            run_request(req, rdata, lat);
            if (is_cacheable(req.addr)) begin
                cacheable_reqs++;
                widx = req.addr[16:3];
                check_value("hit_count_o + miss_count_o", hit_count + miss_count,
                            hits0 + misses0 + 64'd1);
                if (req.we) begin
                    shadow[widx] = merge_word(shadow[widx], req.wdata, req.wstrb);
                end else begin
                    check_value("cpu_rdata_o", rdata, shadow[widx]);
                end
                take_bits(1, r);
                if (r[0]) begin   // back-to-back reread must hit
                    req.we  = 1'b0;
                    hits0   = hit_count;
                    misses0 = miss_count;
                    run_request(req, rdata, lat);
                    cacheable_reqs++;
                    check_value("cpu_rdata_o", rdata, shadow[widx]);
                    check_value("hit_count_o", hit_count, hits0 + 64'd1);
                    check_value("miss_count_o", miss_count, misses0);
                    check_value("cpu_ready_o latency", 64'(lat), 64'd2);
                end
            end else begin
                didx = req.addr[4:3];
                check_value("hit_count_o", hit_count, hits0);
                check_value("miss_count_o", miss_count, misses0);
                if (req.we) begin
                    dev_shadow[didx] = merge_word(dev_shadow[didx], req.wdata, req.wstrb);
                    check_value("device register", u_mem.dev_q[didx], dev_shadow[didx]);
                end else begin
                    check_value("cpu_rdata_o", rdata, dev_shadow[didx]);
                end
            end
        end

        @(posedge clk);
        cpu_valid <= 1'b0;
        @(negedge clk);
        check_value("hit_count_o + miss_count_o", hit_count + miss_count,
                    64'(cacheable_reqs));
        if (writebacks == 0) begin
            fail_run("no dirty line was written back during the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_mem_model.sv ====
/*
 * memory and device responder
 * serves the cache's read and write burst ports from a backing memory
 * and four device registers, with random ready stalls
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        rd_valid_i,
    input  mem_rd_req_t rd_req_i,
    output logic        rd_ready_o,
    output logic [63:0] rd_data_o,
    output logic        rd_last_o,
    input  logic        wr_valid_i,
    input  mem_wr_req_t wr_req_i,
    input  logic [63:0] wr_data_i,
    output logic        wr_ready_o,
    output logic        wr_last_o
);

    localparam int MEM_WORDS = 16384;   // 0x8000_0000 .. 0x8001_ffff

    logic [63:0] mem_q [MEM_WORDS];
    logic [63:0] dev_q [4];
    logic [31:0] lfsr_q;
    logic [7:0]  rd_beat_q;
    logic [7:0]  wr_beat_q;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] read_word(input logic [31:0] a);
        if (a[31:27] == MEM_REGION_TAG) begin
            return mem_q[a[16:3]];
        end
        return dev_q[a[4:3]];
    endfunction

    task automatic write_word(input logic [31:0] a, input logic [63:0] d, input logic [7:0] strb);
        for (int b = 0; b < 8; b++) begin
            if (strb[b] && a[31:27] == MEM_REGION_TAG) begin
                mem_q[a[16:3]][b*8 +: 8] = d[b*8 +: 8];
            end else if (strb[b]) begin
                dev_q[a[4:3]][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endtask

    always @(posedge clk) begin : serve
        logic [31:0] s;
        logic [7:0]  beat;
        if (rst) begin
            rd_ready_o <= 1'b0;
            rd_last_o  <= 1'b0;
            wr_ready_o <= 1'b0;
            wr_last_o  <= 1'b0;
            rd_beat_q  <= '0;
            wr_beat_q  <= '0;
            lfsr_q     <= 32'ha49f;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] = {32'h8000_0000 | 32'(i << 3), ~(32'(i) * 32'h9e37_79b9)};
            end
            for (int k = 0; k < 4; k++) begin
                dev_q[k] = 64'hd0d0_0000_0000_0000 | 64'(k);
            end
        end else begin
            s = lfsr_q;
            rd_ready_o <= 1'b0;
            rd_last_o  <= 1'b0;
            wr_ready_o <= 1'b0;
            wr_last_o  <= 1'b0;
            if (rd_valid_i) begin
                beat = rd_beat_q + 8'(rd_ready_o);   // beat just taken
                s = lfsr_next(s);
                if (rd_ready_o && rd_last_o) begin
                    beat = '0;
                end else if (!s[0]) begin
                    rd_ready_o <= 1'b1;
                    rd_last_o  <= (beat == rd_req_i.len - 8'd1);
                    rd_data_o  <= read_word(rd_req_i.addr + {21'd0, beat, 3'd0});
                end
                rd_beat_q <= beat;
            end
            if (wr_valid_i) begin
                beat = wr_beat_q;
                s = lfsr_next(s);
                if (wr_ready_o) begin
                    write_word(wr_req_i.addr + {21'd0, beat, 3'd0}, wr_data_i, wr_req_i.strb);
                    beat = beat + 8'd1;
                end
                if (wr_ready_o && wr_last_o) begin
                    beat = '0;
                end else if (!s[0]) begin
                    wr_ready_o <= 1'b1;
                    wr_last_o  <= (beat == wr_req_i.len - 8'd1);
                end
                wr_beat_q <= beat;
            end
            lfsr_q <= s;
        end
    end

endmodule

`default_nettype wire
